// ==== vid_pkg.sv ====
// ==========================================================
// Shared geometry, widths and bus structs for the tile video
// subsystem. Every module refers to these by scoped name.
// ==========================================================

package vid_pkg;

    // Screen geometry in pixels and lines
    localparam int H_TOTAL   = 48;
    localparam int H_VISIBLE = 32;
    localparam int V_TOTAL   = 20;
    localparam int V_VISIBLE = 16;

    // Pixel periods from h/v to rgb
    localparam int PXL_DLY = 10;

    localparam int TILE_COLS = 4;

    localparam logic [3:0] CHAR_TRANSP = 4'hf;

    typedef logic [5:0]  hpos_t;
    typedef logic [4:0]  vpos_t;
    typedef logic [7:0]  code_t;
    typedef logic [3:0]  nibble_t;
    // Tile code bits 7:6, then the nibble
    typedef logic [5:0]  scr_pxl_t;
    typedef logic [6:0]  pal_idx_t;
    // Tile code, then row within the tile
    typedef logic [10:0] chrom_addr_t;
    // Map row, then map column
    typedef logic [9:0]  map_addr_t;
    // Eight nibbles, column 0 in the low nibble
    typedef logic [31:0] gfx_row_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    typedef struct packed {
        logic       we;
        logic [2:0] addr;
        code_t      data;
    } cpu_wr_t;

    typedef struct packed {
        logic     we;
        pal_idx_t addr;
        rgb_t     data;
    } prog_wr_t;

    typedef struct packed {
        logic [7:0] hpos;
        logic [7:0] vpos;
    } scroll_t;

endpackage

// ==== vid_timing.sv ====
// ==========================================================
// Video timing generator. Makes the pixel enable, the h/v
// counters and the active-high visible flags for all layers.
// ==========================================================

module vid_timing (
    input  logic           clk,
    input  logic           arst_n,
    output logic           pxl_cen,
    output vid_pkg::hpos_t h,
    output vid_pkg::vpos_t v,
    output logic           lhbl,
    output logic           lvbl
);

    vid_pkg::hpos_t h_nxt;
    vid_pkg::vpos_t v_nxt;

    always_comb begin
        h_nxt = h + 1'b1;
        v_nxt = v;
        if (h == vid_pkg::hpos_t'(vid_pkg::H_TOTAL - 1)) begin
            h_nxt = '0;
            if (v == vid_pkg::vpos_t'(vid_pkg::V_TOTAL - 1)) begin
                v_nxt = '0;
            end else begin
                v_nxt = v + 1'b1;
            end
        end
    end

    // Flags are decoded from the next count so they line up with h and v
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pxl_cen <= 1'b0;
            h       <= '0;
            v       <= '0;
            // Position 0,0 lies in the visible area
            lhbl    <= 1'b1;
            lvbl    <= 1'b1;
        end else begin
            pxl_cen <= ~pxl_cen;
            if (pxl_cen) begin
                h    <= h_nxt;
                v    <= v_nxt;
                lhbl <= h_nxt < vid_pkg::hpos_t'(vid_pkg::H_VISIBLE);
                lvbl <= v_nxt < vid_pkg::vpos_t'(vid_pkg::V_VISIBLE);
            end
        end
    end

endmodule

// ==== vid_char.sv ====
// ==========================================================
// Fixed character layer. The CPU writes eight tile codes;
// each tile row is fetched from the character ROM one tile
// ahead and shifted out a nibble per pixel enable.
// ==========================================================

module vid_char (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  pxl_cen,
    input  vid_pkg::hpos_t        h,
    input  vid_pkg::vpos_t        v,
    input  vid_pkg::cpu_wr_t      cpu_wr,
    output vid_pkg::chrom_addr_t  char_addr,
    input  vid_pkg::gfx_row_t     char_data,
    output vid_pkg::nibble_t      char_pxl
);

    vid_pkg::code_t    tile_ram [8];
    vid_pkg::code_t    code;
    vid_pkg::gfx_row_t shifter;
    logic [2:0]        tile_col;
    logic [1:0]        tile_row;
    logic [2:0]        tile_idx;
    logic              in_grid;

    // CPU port, taken on any clock
    always_ff @(posedge clk) begin
        if (cpu_wr.we) begin
            tile_ram[cpu_wr.addr] <= cpu_wr.data;
        end
    end

    assign tile_col = h[5:3];
    assign tile_row = v[4:3];
    assign tile_idx = 3'(int'(tile_row) * vid_pkg::TILE_COLS + int'(tile_col));
    assign in_grid  = (int'(tile_col) < vid_pkg::TILE_COLS) &&
                      (v < vid_pkg::vpos_t'(vid_pkg::V_VISIBLE));

    // Blank area shows tile 0
    assign code = in_grid ? tile_ram[tile_idx] : '0;

    // Address goes out at column 6, data is back before column 7 ends
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            char_addr <= '0;
        end else if (pxl_cen && h[2:0] == 3'd6) begin
            char_addr <= {code, v[2:0]};
        end
    end

    // Output trails h by one whole tile
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            if (h[2:0] == 3'd7) begin
                shifter <= char_data;
            end else begin
                shifter <= {vid_pkg::CHAR_TRANSP, shifter[31:4]};
            end
        end
    end

    assign char_pxl = shifter[3:0];

endmodule

// ==== vid_scroll.sv ====
// ==========================================================
// Scrolling background layer. Reads the tile map and the
// graphics row at the scrolled position and shifts out the
// nibbles with the palette bits of the tile code.
// ==========================================================

module vid_scroll (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  pxl_cen,
    input  vid_pkg::hpos_t        h,
    input  vid_pkg::vpos_t        v,
    input  vid_pkg::scroll_t      scroll,
    output vid_pkg::map_addr_t    map_addr,
    input  vid_pkg::code_t        map_data,
    output vid_pkg::chrom_addr_t  scr_addr,
    input  vid_pkg::gfx_row_t     scr_data,
    output vid_pkg::scr_pxl_t     scr_pxl
);

    vid_pkg::scroll_t  scroll_l;
    vid_pkg::hpos_t    h_la;
    vid_pkg::vpos_t    v_la;
    vid_pkg::gfx_row_t shifter;
    logic              wrap;
    logic [7:0]        x_la;
    logic [7:0]        y_la;
    logic [2:0]        row_l;
    logic [1:0]        pal_l;
    logic [1:0]        pal_sh;

    // One position per frame, taken early in the last blank line
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scroll_l <= '0;
        end else if (pxl_cen && h == '0 &&
                     v == vid_pkg::vpos_t'(vid_pkg::V_TOTAL - 1)) begin
            scroll_l <= scroll;
        end
    end

    // Fetch looks two pixels ahead, to the pixel where the row gets loaded.
    // Tiles that straddle the line wrap keep their visible part after it.
    assign wrap = h >= vid_pkg::hpos_t'(vid_pkg::H_TOTAL - 2);
    assign h_la = wrap ? h - vid_pkg::hpos_t'(vid_pkg::H_TOTAL - 2)
                       : h + vid_pkg::hpos_t'(2);

    always_comb begin
        v_la = v;
        if (wrap) begin
            if (v == vid_pkg::vpos_t'(vid_pkg::V_TOTAL - 1)) begin
                v_la = '0;
            end else begin
                v_la = v + 1'b1;
            end
        end
    end

    // Modulo 256 map coordinates
    assign x_la = 8'(h_la) + scroll_l.hpos;
    assign y_la = 8'(v_la) + scroll_l.vpos;

    // Phase 7 map read, phase 0 graphics read, phase 1 load
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            map_addr <= '0;
            scr_addr <= '0;
        end else if (pxl_cen) begin
            case (x_la[2:0])
                3'd7:    map_addr <= {y_la[7:3], x_la[7:3]};
                3'd0:    scr_addr <= {map_data, row_l};
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            if (x_la[2:0] == 3'd7) begin
                row_l <= y_la[2:0];
            end
            if (x_la[2:0] == 3'd0) begin
                pal_l <= map_data[7:6];
            end
            if (x_la[2:0] == 3'd1) begin
                shifter <= scr_data;
                pal_sh  <= pal_l;
            end else begin
                shifter <= {4'h0, shifter[31:4]};
            end
        end
    end

    assign scr_pxl = {pal_sh, shifter[3:0]};

endmodule

// ==== vid_colmix.sv ====
// ==========================================================
// Colour mixer. Puts characters over the scroll layer, looks
// the result up in the programmable palette and blanks it.
// Adds two pixel periods to the layer outputs.
// ==========================================================

module vid_colmix (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               pxl_cen,
    input  logic               lhbl,
    input  logic               lvbl,
    input  vid_pkg::nibble_t   char_pxl,
    input  vid_pkg::scr_pxl_t  scr_pxl,
    input  vid_pkg::prog_wr_t  prog,
    output logic               lhbl_dly,
    output logic               lvbl_dly,
    output vid_pkg::rgb_t      rgb
);

    vid_pkg::rgb_t                pal_ram [2**$bits(vid_pkg::pal_idx_t)];
    vid_pkg::rgb_t                pal_rgb;
    vid_pkg::pal_idx_t            idx;
    logic [vid_pkg::PXL_DLY-1:0]  hbl_sr;
    logic [vid_pkg::PXL_DLY-1:0]  vbl_sr;

    // Palette programming port
    always_ff @(posedge clk) begin
        if (prog.we) begin
            pal_ram[prog.addr] <= prog.data;
        end
    end

    // Characters win unless transparent
    always_comb begin
        if (char_pxl != vid_pkg::CHAR_TRANSP) begin
            idx = {1'b1, 2'b00, char_pxl};
        end else begin
            idx = {1'b0, scr_pxl};
        end
    end

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            pal_rgb <= pal_ram[idx];
        end
    end

    // Blanking travels the whole pipeline, layers included
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hbl_sr <= '0;
            vbl_sr <= '0;
            rgb    <= '0;
        end else if (pxl_cen) begin
            hbl_sr <= {hbl_sr[vid_pkg::PXL_DLY-2:0], lhbl};
            vbl_sr <= {vbl_sr[vid_pkg::PXL_DLY-2:0], lvbl};
            // Tap one stage early so rgb and the flags change together
            if (hbl_sr[vid_pkg::PXL_DLY-2] && vbl_sr[vid_pkg::PXL_DLY-2]) begin
                rgb <= pal_rgb;
            end else begin
                rgb <= '0;
            end
        end
    end

    assign lhbl_dly = hbl_sr[vid_pkg::PXL_DLY-1];
    assign lvbl_dly = vbl_sr[vid_pkg::PXL_DLY-1];

endmodule

// ==== vid_top.sv ====
// ==========================================================
// Top of the video subsystem. Connects the timing generator,
// the character and scroll layers and the colour mixer to
// the ROM, CPU, palette programming and video ports.
// ==========================================================

module vid_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  vid_pkg::cpu_wr_t      cpu_wr,
    input  vid_pkg::prog_wr_t     prog,
    input  vid_pkg::scroll_t      scroll,
    // Character ROM
    output vid_pkg::chrom_addr_t  char_addr,
    input  vid_pkg::gfx_row_t     char_data,
    // Scroll map and graphics ROMs
    output vid_pkg::map_addr_t    map_addr,
    input  vid_pkg::code_t        map_data,
    output vid_pkg::chrom_addr_t  scr_addr,
    input  vid_pkg::gfx_row_t     scr_data,
    // Video
    output vid_pkg::hpos_t        h,
    output vid_pkg::vpos_t        v,
    output logic                  lhbl,
    output logic                  lvbl,
    output logic                  lhbl_dly,
    output logic                  lvbl_dly,
    output vid_pkg::rgb_t         rgb
);

    logic              pxl_cen;
    vid_pkg::nibble_t  char_pxl;
    vid_pkg::scr_pxl_t scr_pxl;

    vid_timing u_timing (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .pxl_cen  ( pxl_cen  ),
        .h        ( h        ),
        .v        ( v        ),
        .lhbl     ( lhbl     ),
        .lvbl     ( lvbl     )
    );

    vid_char u_char (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .pxl_cen   ( pxl_cen   ),
        .h         ( h         ),
        .v         ( v         ),
        .cpu_wr    ( cpu_wr    ),
        .char_addr ( char_addr ),
        .char_data ( char_data ),
        .char_pxl  ( char_pxl  )
    );

    vid_scroll u_scroll (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .pxl_cen  ( pxl_cen  ),
        .h        ( h        ),
        .v        ( v        ),
        .scroll   ( scroll   ),
        .map_addr ( map_addr ),
        .map_data ( map_data ),
        .scr_addr ( scr_addr ),
        .scr_data ( scr_data ),
        .scr_pxl  ( scr_pxl  )
    );

    vid_colmix u_colmix (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .pxl_cen  ( pxl_cen  ),
        .lhbl     ( lhbl     ),
        .lvbl     ( lvbl     ),
        .char_pxl ( char_pxl ),
        .scr_pxl  ( scr_pxl  ),
        .prog     ( prog     ),
        .lhbl_dly ( lhbl_dly ),
        .lvbl_dly ( lvbl_dly ),
        .rgb      ( rgb      )
    );

endmodule

// ==== vid_assert.sv ====
// ==========================================================
// Concurrent checks bound into the video top: pixel enable
// cadence, black output in blanking and the reset state.
// ==========================================================

module vid_assert (
    input logic          clk,
    input logic          arst_n,
    input logic          pxl_cen,
    input logic          lhbl_dly,
    input logic          lvbl_dly,
    input vid_pkg::rgb_t rgb
);

    timeunit 1ns;
    timeprecision 1ps;

    cen_alternates: assert property (@(posedge clk) disable iff (!arst_n)
        $past(arst_n) |-> pxl_cen != $past(pxl_cen))
        else $error("pixel enable did not alternate");

    blank_is_black: assert property (@(posedge clk) disable iff (!arst_n)
        (!lhbl_dly || !lvbl_dly) |-> rgb == '0)
        else $error("colour output not black during blanking");

    // Sampled on the falling edge, after the reset has been applied
    reset_state: assert property (@(negedge clk)
        !arst_n |-> (rgb == '0 && !lhbl_dly && !lvbl_dly))
        else $error("outputs not cleared during reset");

endmodule

bind vid_top vid_assert u_assert (
    .clk      ( clk      ),
    .arst_n   ( arst_n   ),
    .pxl_cen  ( pxl_cen  ),
    .lhbl_dly ( lhbl_dly ),
    .lvbl_dly ( lvbl_dly ),
    .rgb      ( rgb      )
);

// ==== vid_tb.sv ====
// ==========================================================
// Testbench for the tile video subsystem. Models the ROMs,
// loads palette, tile codes and scroll positions during
// vertical blanking and checks every pixel against a model.
// ==========================================================

module vid_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_HALF       = 20;
    // Four frames of 1920 clocks plus reset and setup
    localparam int TIMEOUT_CYCLES = 9000;

    typedef struct packed {
        vid_pkg::hpos_t h;
        vid_pkg::vpos_t v;
        logic           lhbl;
        logic           lvbl;
    } hist_t;

    logic                 clk;
    logic                 arst_n;
    vid_pkg::cpu_wr_t     cpu_wr;
    vid_pkg::prog_wr_t    prog;
    vid_pkg::scroll_t     scroll;
    vid_pkg::chrom_addr_t char_addr;
    vid_pkg::gfx_row_t    char_data = '0;
    vid_pkg::map_addr_t   map_addr;
    vid_pkg::code_t       map_data = '0;
    vid_pkg::chrom_addr_t scr_addr;
    vid_pkg::gfx_row_t    scr_data = '0;
    vid_pkg::hpos_t       h;
    vid_pkg::vpos_t       v;
    logic                 lhbl;
    logic                 lvbl;
    logic                 lhbl_dly;
    logic                 lvbl_dly;
    vid_pkg::rgb_t        rgb;

    integer               seed;
    logic [31:0]          rom_key;
    vid_pkg::rgb_t        pal_model [128];
    vid_pkg::code_t       tile_model [8];
    vid_pkg::scroll_t     scroll_lat;
    hist_t                hist [$];
    logic                 rgb_check_en;
    int                   err_count;
    int                   cycles = 0;
    // Screen position the DUT should show next
    vid_pkg::hpos_t       exp_h = '0;
    vid_pkg::vpos_t       exp_v = '0;

    vid_top vid_top_i (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .cpu_wr    ( cpu_wr    ),
        .prog      ( prog      ),
        .scroll    ( scroll    ),
        .char_addr ( char_addr ),
        .char_data ( char_data ),
        .map_addr  ( map_addr  ),
        .map_data  ( map_data  ),
        .scr_addr  ( scr_addr  ),
        .scr_data  ( scr_data  ),
        .h         ( h         ),
        .v         ( v         ),
        .lhbl      ( lhbl      ),
        .lvbl      ( lvbl      ),
        .lhbl_dly  ( lhbl_dly  ),
        .lvbl_dly  ( lvbl_dly  ),
        .rgb       ( rgb       )
    );

    initial begin
        clk = 1'b0;
    end

    always #CLK_HALF clk = ~clk;

    function automatic logic [31:0] hash32(input logic [31:0] a);
        logic [31:0] x;
        x = a ^ rom_key;
        x = x * 32'h9e3779b1;
        x = x ^ (x >> 15);
        x = x * 32'h85ebca77;
        x = x ^ (x >> 13);
        return x;
    endfunction

    // About a quarter of the character nibbles are transparent
    function automatic vid_pkg::gfx_row_t char_rom(input vid_pkg::chrom_addr_t addr);
        vid_pkg::gfx_row_t row;
        logic [31:0]       mask;
        row  = hash32({21'h1, addr});
        mask = hash32({21'h2, addr});
        for (int c = 0; c < 8; c++) begin
            if (mask[2*c +: 2] == 2'b00) begin
                row[4*c +: 4] = vid_pkg::CHAR_TRANSP;
            end
        end
        return row;
    endfunction

    function automatic vid_pkg::gfx_row_t scr_rom(input vid_pkg::chrom_addr_t addr);
        return hash32({21'h3, addr});
    endfunction

    function automatic vid_pkg::code_t map_rom(input vid_pkg::map_addr_t addr);
        logic [31:0] x;
        x = hash32({22'h4, addr});
        return x[7:0];
    endfunction

    // ROMs answer one clock after the address
    always @(posedge clk) begin
        char_data <= char_rom(char_addr);
        map_data  <= map_rom(map_addr);
        scr_data  <= scr_rom(scr_addr);
    end

    // Expected colour of a visible position
    function automatic vid_pkg::rgb_t ref_rgb(input vid_pkg::hpos_t hh,
                                              input vid_pkg::vpos_t vv);
        logic [2:0]        tidx;
        vid_pkg::code_t    code;
        vid_pkg::code_t    mcode;
        vid_pkg::gfx_row_t crow;
        vid_pkg::gfx_row_t srow;
        vid_pkg::nibble_t  cn;
        vid_pkg::pal_idx_t idx;
        logic [7:0]        x;
        logic [7:0]        y;
        tidx = 3'(int'(vv[4:3]) * vid_pkg::TILE_COLS + int'(hh[5:3]));
        code = tile_model[tidx];
        crow = char_rom({code, vv[2:0]});
        cn   = crow[4*int'(hh[2:0]) +: 4];
        if (cn != vid_pkg::CHAR_TRANSP) begin
            idx = {1'b1, 2'b00, cn};
        end else begin
            x     = 8'(hh) + scroll_lat.hpos;
            y     = 8'(vv) + scroll_lat.vpos;
            mcode = map_rom({y[7:3], x[7:3]});
            srow  = scr_rom({mcode, y[2:0]});
            idx   = {1'b0, mcode[7:6], srow[4*int'(x[2:0]) +: 4]};
        end
        return pal_model[idx];
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("FAIL time=%0t signal=%s got=%0h expected=%0h", $time, name, got, exp);
            $display("Done: errors found");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Compare on every pixel enable against the position PXL_DLY earlier
    always @(posedge clk) begin
        hist_t e;
        hist_t old;
        if (arst_n && vid_top_i.pxl_cen) begin
            check_val("h", 32'(h), 32'(exp_h));
            check_val("v", 32'(v), 32'(exp_v));
            e.h    = exp_h;
            e.v    = exp_v;
            e.lhbl = exp_h < vid_pkg::hpos_t'(vid_pkg::H_VISIBLE);
            e.lvbl = exp_v < vid_pkg::vpos_t'(vid_pkg::V_VISIBLE);
            check_val("lhbl", 32'(lhbl), 32'(e.lhbl));
            check_val("lvbl", 32'(lvbl), 32'(e.lvbl));
            if (exp_v == vid_pkg::vpos_t'(vid_pkg::V_TOTAL - 1) && exp_h == '0) begin
                scroll_lat = scroll;
            end
            hist.push_back(e);
            if (hist.size() > vid_pkg::PXL_DLY) begin
                old = hist.pop_front();
                check_val("lhbl_dly", 32'(lhbl_dly), 32'(old.lhbl));
                check_val("lvbl_dly", 32'(lvbl_dly), 32'(old.lvbl));
                if (!(old.lhbl && old.lvbl)) begin
                    check_val("rgb", 32'(rgb), 32'h0);
                end else if (rgb_check_en) begin
                    check_val("rgb", 32'(rgb), 32'(ref_rgb(old.h, old.v)));
                end
            end
            // Raster order over the full line and frame totals
            if (exp_h == vid_pkg::hpos_t'(vid_pkg::H_TOTAL - 1)) begin
                exp_h = '0;
                if (exp_v == vid_pkg::vpos_t'(vid_pkg::V_TOTAL - 1)) begin
                    exp_v = '0;
                end else begin
                    exp_v = exp_v + 1'b1;
                end
            end else begin
                exp_h = exp_h + 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("The test ran out of time after %0d cycles", cycles);
            $display("Done: errors found");
            $fatal(1, "Timeout");
        end
    end

    // Returns on the pixel enable that starts the given line
    task automatic wait_line(input vid_pkg::vpos_t line);
        do begin
            @(posedge clk);
        end while (!(vid_top_i.pxl_cen && v == line && h == '0));
    endtask

    task automatic pal_write(input vid_pkg::pal_idx_t idx, input vid_pkg::rgb_t val);
        prog <= {1'b1, idx, val};
        pal_model[idx] = val;
        @(posedge clk);
    endtask

    task automatic tile_write(input logic [2:0] addr, input vid_pkg::code_t code);
        cpu_wr <= {1'b1, addr, code};
        tile_model[addr] = code;
        @(posedge clk);
    endtask

    // Random palette and tile updates, finished inside vertical blanking
    task automatic update_some(input int n_pal, input int n_tile);
        logic [31:0] r;
        for (int i = 0; i < n_pal; i++) begin
            r = $random(seed);
            pal_write(r[18:12], r[11:0]);
        end
        prog <= '0;
        for (int i = 0; i < n_tile; i++) begin
            r = $random(seed);
            tile_write(r[10:8], r[7:0]);
        end
        cpu_wr <= '0;
    endtask

    initial begin
        logic [31:0] r;
        seed         = 32'h1354;
        rom_key      = $random(seed);
        arst_n       = 1'b0;
        cpu_wr       = '0;
        prog         = '0;
        scroll       = '0;
        scroll_lat   = '0;
        rgb_check_en = 1'b0;
        err_count    = 0;

        @(posedge clk);
        @(negedge clk);
        check_val("rgb", 32'(rgb), 32'h0);
        check_val("lhbl_dly", 32'(lhbl_dly), 32'h0);
        check_val("lvbl_dly", 32'(lvbl_dly), 32'h0);
        check_val("h", 32'(h), 32'h0);
        check_val("v", 32'(v), 32'h0);
        @(posedge clk);
        arst_n <= 1'b1;

        // Full load in the first vertical blanking
        wait_line(vid_pkg::vpos_t'(vid_pkg::V_VISIBLE));
        for (int i = 0; i < 128; i++) begin
            r = $random(seed);
            pal_write(vid_pkg::pal_idx_t'(i), r[11:0]);
        end
        prog <= '0;
        for (int i = 0; i < 8; i++) begin
            r = $random(seed);
            tile_write(3'(i), r[7:0]);
        end
        cpu_wr <= '0;
        r = $random(seed);
        scroll <= r[15:0];
        rgb_check_en = 1'b1;

        // Scroll position that wraps both map coordinates
        wait_line(vid_pkg::vpos_t'(vid_pkg::V_VISIBLE));
        scroll <= {8'hfb, 8'hf6};
        update_some(16, 3);

        wait_line(vid_pkg::vpos_t'(vid_pkg::V_VISIBLE));
        r = $random(seed);
        scroll <= r[15:0];
        update_some(24, 4);

        wait_line(vid_pkg::vpos_t'(vid_pkg::V_VISIBLE));
        if (err_count == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1, "Errors were found");
        end
    end

endmodule

// ==== filelist.f ====
vid_pkg.sv
vid_timing.sv
vid_char.sv
vid_scroll.sv
vid_colmix.sv
vid_top.sv
vid_assert.sv
vid_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the video testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module vid_tb -f filelist.f -o vid_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/vid_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" sim.log; then
    echo "Simulation reported errors"
    exit 1
fi
echo "Simulation passed"
exit 0
